/* design/rv_front_pkg.sv */
`default_nettype none

package rv_front_pkg;

  localparam int XLEN = 64;

  // add also serves loads, stores, jumps and auipc
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_AND,
    ALU_OR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  typedef enum logic [3:0] {
    MEM_NONE,
    MEM_LB,
    MEM_LH,
    MEM_LW,
    MEM_LD,
    MEM_LBU,
    MEM_LHU,
    MEM_LWU,
    MEM_SB,
    MEM_SH,
    MEM_SW,
    MEM_SD
  } mem_op_e;

  // execute class, one per opcode group
  typedef enum logic [3:0] {
    EXC_NONE,
    EXC_AUIPC,
    EXC_LUI,
    EXC_JAL,
    EXC_JALR,
    EXC_LOAD,
    EXC_STORE,
    EXC_BRANCH,
    EXC_OPIMM,
    EXC_OPIMM32,
    EXC_OP,
    EXC_OP32
  } exc_op_e;

  typedef enum logic [1:0] {
    PC_INC4,
    PC_BRANCH,
    PC_JAL,
    PC_JALR
  } pc_op_e;

  typedef struct packed {
    logic [4:0]      rs1_idx;
    logic [4:0]      rs2_idx;
    logic [4:0]      rd_idx;
    logic [XLEN-1:0] imm;
    logic            need_rs1;
    logic            need_rs2;
    logic            need_rd;
    logic            need_imm;
    alu_op_e         alu_op;
    mem_op_e         mem_op;
    exc_op_e         exc_op;
    pc_op_e          pc_op;
  } decode_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;
  } fetch_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    decode_t         dec;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
  } issue_t;

  // read-only wishbone master request
  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic [XLEN-1:0] adr;
  } wb_req_t;

endpackage

`default_nettype wire

/* design/inst_fetch.sv */
`default_nettype none

module inst_fetch import rv_front_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] wb_dat,
  input  logic        wb_ack,
  input  logic        fetch_ready,
  output wb_req_t     wb,
  output logic        fetch_valid,
  output fetch_t      fetch
);

  logic            req_q;
  logic [XLEN-1:0] pc_q;
  logic            buf_valid_q;
  fetch_t          buf_q;
  logic            ack_hit;
  logic            drain;
  logic            start;

  assign ack_hit = req_q && wb_ack;
  assign drain   = buf_valid_q && fetch_ready;

  // a read only goes out once the buffer is free,
  // so an ack can never land on a held word
  assign start = !req_q && (!buf_valid_q || drain);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q       <= 1'b0;
      pc_q        <= RESET_PC;
      buf_valid_q <= 1'b0;
    end else begin
      if (ack_hit) begin
        req_q <= 1'b0;
        pc_q  <= pc_q + XLEN'(4);
      end else if (start) begin
        req_q <= 1'b1;
      end
      if (ack_hit) begin
        buf_valid_q <= 1'b1;
      end else if (drain) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  // word captured together with its address
  always_ff @(posedge clk) begin
    if (ack_hit) begin
      buf_q.pc   <= pc_q;
      buf_q.inst <= wb_dat;
    end
  end

  always_comb begin
    wb.cyc = req_q;
    wb.stb = req_q;
    wb.adr = pc_q;
  end

  assign fetch_valid = buf_valid_q;
  assign fetch       = buf_q;

endmodule

`default_nettype wire

/* design/inst_decode.sv */
`default_nettype none

module inst_decode import rv_front_pkg::*; (
  input  logic [31:0] inst,
  output decode_t     dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;

  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // opcode classes kept by this front end
  logic t_load, t_store, t_branch, t_jalr, t_jal;
  logic t_opimm, t_op, t_auipc, t_lui, t_opimm32, t_op32;

  assign t_load    = (opcode == 7'b0000011);
  assign t_store   = (opcode == 7'b0100011);
  assign t_branch  = (opcode == 7'b1100011);
  assign t_jalr    = (opcode == 7'b1100111);
  assign t_jal     = (opcode == 7'b1101111);
  assign t_opimm   = (opcode == 7'b0010011);
  assign t_op      = (opcode == 7'b0110011);
  assign t_auipc   = (opcode == 7'b0010111);
  assign t_lui     = (opcode == 7'b0110111);
  assign t_opimm32 = (opcode == 7'b0011011);
  assign t_op32    = (opcode == 7'b0111011);

  logic f7_zero, f7_alt;
  logic sh_zero, sh_alt;

  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);
  // rv64 shift amounts take funct7 bit 0
  assign sh_zero = (funct7[6:1] == 6'b000000);
  assign sh_alt  = (funct7[6:1] == 6'b010000);

  // formats
  logic r_fmt, i_fmt, s_fmt, b_fmt, u_fmt, j_fmt;

  assign r_fmt = t_op | t_op32;
  assign i_fmt = t_load | t_opimm | t_opimm32 | t_jalr;
  assign s_fmt = t_store;
  assign b_fmt = t_branch;
  assign u_fmt = t_auipc | t_lui;
  assign j_fmt = t_jal;

  logic need_rs1, need_rs2, need_rd, need_imm;

  assign need_rs1 = r_fmt | i_fmt | s_fmt | b_fmt;
  assign need_rs2 = r_fmt | s_fmt | b_fmt;
  assign need_rd  = r_fmt | i_fmt | u_fmt | j_fmt;
  assign need_imm = i_fmt | s_fmt | b_fmt | u_fmt | j_fmt;

  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign imm_i = {{(XLEN-11){inst[31]}}, inst[30:20]};
  assign imm_s = {{(XLEN-11){inst[31]}}, inst[30:25], inst[11:7]};
  assign imm_b = {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-31){inst[31]}}, inst[30:12], 12'b0};
  assign imm_j = {{(XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // alu groups, 32-bit and 64-bit forms together
  logic alu_add, alu_sub, alu_xor, alu_and, alu_or, alu_sll, alu_srl, alu_sra;

  assign alu_add = ((t_op | t_op32) & (funct3 == 3'b000) & f7_zero)
                 | ((t_opimm | t_opimm32) & (funct3 == 3'b000))
                 | t_load | t_store | t_jal | t_jalr | t_auipc;
  assign alu_sub = (t_op | t_op32) & (funct3 == 3'b000) & f7_alt;
  assign alu_xor = (t_op & (funct3 == 3'b100) & f7_zero) | (t_opimm & (funct3 == 3'b100));
  assign alu_or  = (t_op & (funct3 == 3'b110) & f7_zero) | (t_opimm & (funct3 == 3'b110));
  assign alu_and = (t_op & (funct3 == 3'b111) & f7_zero) | (t_opimm & (funct3 == 3'b111));
  assign alu_sll = ((t_op | t_op32 | t_opimm32) & (funct3 == 3'b001) & f7_zero)
                 | (t_opimm & (funct3 == 3'b001) & sh_zero);
  assign alu_srl = ((t_op | t_op32 | t_opimm32) & (funct3 == 3'b101) & f7_zero)
                 | (t_opimm & (funct3 == 3'b101) & sh_zero);
  assign alu_sra = ((t_op | t_op32 | t_opimm32) & (funct3 == 3'b101) & f7_alt)
                 | (t_opimm & (funct3 == 3'b101) & sh_alt);

  always_comb begin
    dec.rs1_idx  = need_rs1 ? rs1 : 5'd0;
    dec.rs2_idx  = need_rs2 ? rs2 : 5'd0;
    dec.rd_idx   = need_rd ? rd : 5'd0;
    dec.need_rs1 = need_rs1;
    dec.need_rs2 = need_rs2;
    dec.need_rd  = need_rd;
    dec.need_imm = need_imm;

    if (i_fmt)      dec.imm = imm_i;
    else if (s_fmt) dec.imm = imm_s;
    else if (b_fmt) dec.imm = imm_b;
    else if (u_fmt) dec.imm = imm_u;
    else if (j_fmt) dec.imm = imm_j;
    else            dec.imm = '0;

    // M ops fall through to add
    if (alu_add)      dec.alu_op = ALU_ADD;
    else if (alu_sub) dec.alu_op = ALU_SUB;
    else if (alu_xor) dec.alu_op = ALU_XOR;
    else if (alu_and) dec.alu_op = ALU_AND;
    else if (alu_or)  dec.alu_op = ALU_OR;
    else if (alu_sll) dec.alu_op = ALU_SLL;
    else if (alu_srl) dec.alu_op = ALU_SRL;
    else if (alu_sra) dec.alu_op = ALU_SRA;
    else              dec.alu_op = ALU_ADD;

    dec.mem_op = MEM_NONE;
    if (t_load) begin
      case (funct3)
        3'b000:  dec.mem_op = MEM_LB;
        3'b001:  dec.mem_op = MEM_LH;
        3'b010:  dec.mem_op = MEM_LW;
        3'b011:  dec.mem_op = MEM_LD;
        3'b100:  dec.mem_op = MEM_LBU;
        3'b101:  dec.mem_op = MEM_LHU;
        3'b110:  dec.mem_op = MEM_LWU;
        default: dec.mem_op = MEM_NONE;
      endcase
    end else if (t_store) begin
      case (funct3)
        3'b000:  dec.mem_op = MEM_SB;
        3'b001:  dec.mem_op = MEM_SH;
        3'b010:  dec.mem_op = MEM_SW;
        3'b011:  dec.mem_op = MEM_SD;
        default: dec.mem_op = MEM_NONE;
      endcase
    end

    if (t_auipc)          dec.exc_op = EXC_AUIPC;
    else if (t_lui)       dec.exc_op = EXC_LUI;
    else if (t_jal)       dec.exc_op = EXC_JAL;
    else if (t_jalr)      dec.exc_op = EXC_JALR;
    else if (t_load)      dec.exc_op = EXC_LOAD;
    else if (t_store)     dec.exc_op = EXC_STORE;
    else if (t_branch)    dec.exc_op = EXC_BRANCH;
    else if (t_opimm)     dec.exc_op = EXC_OPIMM;
    else if (t_opimm32)   dec.exc_op = EXC_OPIMM32;
    else if (t_op)        dec.exc_op = EXC_OP;
    else if (t_op32)      dec.exc_op = EXC_OP32;
    else                  dec.exc_op = EXC_NONE;

    if (b_fmt)                              dec.pc_op = PC_BRANCH;
    else if (t_jal)                         dec.pc_op = PC_JAL;
    else if (t_jalr && (funct3 == 3'b000))  dec.pc_op = PC_JALR;
    else                                    dec.pc_op = PC_INC4;
  end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`default_nettype none

module reg_file import rv_front_pkg::*; (
  input  logic            clk,
  input  logic [4:0]      rs1_idx,
  input  logic [4:0]      rs2_idx,
  input  logic            wr_en,
  input  logic [4:0]      wr_idx,
  input  logic [XLEN-1:0] wr_data,
  output logic [XLEN-1:0] rs1_val,
  output logic [XLEN-1:0] rs2_val
);

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (wr_en && (wr_idx != 5'd0)) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // no bypass, a same-cycle write shows up next cycle
  always_comb begin
    rs1_val = '0;
    rs2_val = '0;
    if (rs1_idx != 5'd0) rs1_val = regs[rs1_idx];
    if (rs2_idx != 5'd0) rs2_val = regs[rs2_idx];
  end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`default_nettype none

module decode_stage import rv_front_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            fetch_valid,
  input  fetch_t          fetch,
  input  logic            issue_ready,
  input  logic            wr_en,
  input  logic [4:0]      wr_idx,
  input  logic [XLEN-1:0] wr_data,
  output logic            fetch_ready,
  output logic            issue_valid,
  output issue_t          issue
);

  decode_t         dec;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic            accept;

  inst_decode u_decode (
    .inst (fetch.inst),
    .dec  (dec)
  );

  reg_file u_regs (
    .clk     (clk),
    .rs1_idx (dec.rs1_idx),
    .rs2_idx (dec.rs2_idx),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_data (wr_data),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val)
  );

  // room when empty or leaving this cycle
  assign fetch_ready = !issue_valid || issue_ready;
  assign accept      = fetch_valid && fetch_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_valid <= 1'b0;
    end else if (accept) begin
      issue_valid <= 1'b1;
    end else if (issue_ready) begin
      issue_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      issue.pc      <= fetch.pc;
      issue.dec     <= dec;
      issue.rs1_val <= rs1_val;
      issue.rs2_val <= rs2_val;
    end
  end

endmodule

`default_nettype wire

/* design/rv_front_top.sv */
`default_nettype none

module rv_front_top import rv_front_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [31:0]     wb_dat,
  input  logic            wb_ack,
  input  logic            issue_ready,
  input  logic            wr_en,
  input  logic [4:0]      wr_idx,
  input  logic [XLEN-1:0] wr_data,
  output wb_req_t         wb,
  output logic            issue_valid,
  output issue_t          issue
);

  logic   fetch_valid;
  logic   fetch_ready;
  fetch_t fetch;

  inst_fetch #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_dat      (wb_dat),
    .wb_ack      (wb_ack),
    .fetch_ready (fetch_ready),
    .wb          (wb),
    .fetch_valid (fetch_valid),
    .fetch       (fetch)
  );

  // decode, operand read and issue register
  decode_stage u_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch       (fetch),
    .issue_ready (issue_ready),
    .wr_en       (wr_en),
    .wr_idx      (wr_idx),
    .wr_data     (wr_data),
    .fetch_ready (fetch_ready),
    .issue_valid (issue_valid),
    .issue       (issue)
  );

endmodule

`default_nettype wire

/* bench/tb_rv_front.sv */
`default_nettype none

module tb_rv_front import rv_front_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int              CLK_PERIOD     = 20;
  localparam int              RESET_CYCLES   = 4;
  localparam int              PRELOAD_CYCLES = 34;
  localparam int              NUM_VEC        = 29;
  localparam int              FIELDS         = 13;
  localparam int              WATCHDOG_CYCLES = RESET_CYCLES + PRELOAD_CYCLES + 40 * NUM_VEC;
  localparam logic [XLEN-1:0] RESET_PC       = 64'h100;

  logic            clk = 1'b0;
  logic            rst_n;
  logic [31:0]     wb_dat;
  logic            wb_ack;
  logic            issue_ready;
  logic            wr_en;
  logic [4:0]      wr_idx;
  logic [XLEN-1:0] wr_data;
  wb_req_t         wb;
  logic            issue_valid;
  issue_t          issue;

  logic            mem_enable;
  logic [63:0]     vec_mem [0:NUM_VEC*FIELDS-1];
  logic [63:0]     reg_copy [0:31];

  rv_front_top #(
    .RESET_PC (RESET_PC)
  ) UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_dat      (wb_dat),
    .wb_ack      (wb_ack),
    .issue_ready (issue_ready),
    .wr_en       (wr_en),
    .wr_idx      (wr_idx),
    .wr_data     (wr_data),
    .wb          (wb),
    .issue_valid (issue_valid),
    .issue       (issue)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  // word at a bus address, fill pattern outside the vector range
  function automatic logic [31:0] mem_word(input logic [63:0] adr);
    logic [63:0] offset;
    int          idx;
    offset = adr - RESET_PC;
    idx    = int'(offset >> 2);
    if (adr >= RESET_PC && (offset >> 2) < 64'(NUM_VEC)) begin
      return vec_mem[idx*FIELDS][31:0];
    end
    return adr[63:32] ^ adr[31:0];
  endfunction

  task automatic verify_bundle(input int n);
    int    base;
    string tag;
    base = n * FIELDS;
    tag  = $sformatf("vector %0d", n);
    compare_value({tag, " pc"}, RESET_PC + 64'(4 * n), issue.pc);
    compare_value({tag, " rs1_idx"}, vec_mem[base+1], 64'(issue.dec.rs1_idx));
    compare_value({tag, " rs2_idx"}, vec_mem[base+2], 64'(issue.dec.rs2_idx));
    compare_value({tag, " rd_idx"}, vec_mem[base+3], 64'(issue.dec.rd_idx));
    compare_value({tag, " imm"}, vec_mem[base+4], issue.dec.imm);
    compare_value({tag, " need_rs1"}, vec_mem[base+5], 64'(issue.dec.need_rs1));
    compare_value({tag, " need_rs2"}, vec_mem[base+6], 64'(issue.dec.need_rs2));
    compare_value({tag, " need_rd"}, vec_mem[base+7], 64'(issue.dec.need_rd));
    compare_value({tag, " need_imm"}, vec_mem[base+8], 64'(issue.dec.need_imm));
    compare_value({tag, " alu_op"}, vec_mem[base+9], 64'(issue.dec.alu_op));
    compare_value({tag, " mem_op"}, vec_mem[base+10], 64'(issue.dec.mem_op));
    compare_value({tag, " exc_op"}, vec_mem[base+11], 64'(issue.dec.exc_op));
    compare_value({tag, " pc_op"}, vec_mem[base+12], 64'(issue.dec.pc_op));
    // operands named by the expected indices
    compare_value({tag, " rs1_val"}, reg_copy[vec_mem[base+1][4:0]], issue.rs1_val);
    compare_value({tag, " rs2_val"}, reg_copy[vec_mem[base+2][4:0]], issue.rs2_val);
  endtask

  task automatic load_registers();
    logic [63:0] value;
    for (int i = 1; i < 32; i++) begin
      @(posedge clk);
      value       = {$urandom, $urandom};
      wr_en      <= 1'b1;
      wr_idx     <= 5'(i);
      wr_data    <= value;
      reg_copy[i] = value;
    end
    @(posedge clk);
    wr_en      <= 1'b0;
    mem_enable <= 1'b1;
  endtask

  // wishbone slave with random wait states, also tracks the fetch addresses
  initial begin : memory_model
    logic [63:0] exp_adr;
    int          wait_left;
    exp_adr   = RESET_PC;
    wait_left = 0;
    wb_ack    = 1'b0;
    wb_dat    = '0;
    forever begin
      @(posedge clk);
      // cyc and stb move together
      compare_value("wb stb", 64'(wb.cyc), 64'(wb.stb));
      if (wb.cyc && wb.stb) begin
        compare_value("wb adr", exp_adr, wb.adr);
        if (wb_ack) exp_adr = exp_adr + 64'd4;
      end
      if (wb_ack) begin
        wb_ack   <= 1'b0;
        wait_left = $urandom % 4;
      end else if (mem_enable && wb.cyc && wb.stb) begin
        if (wait_left == 0) begin
          wb_ack <= 1'b1;
          wb_dat <= mem_word(wb.adr);
        end else begin
          wait_left = wait_left - 1;
        end
      end
    end
  end

  // back end stalls about a third of the time
  initial begin : backend_stall
    issue_ready = 1'b0;
    forever begin
      @(posedge clk);
      issue_ready <= ($urandom % 3) != 0;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the front end stopped issuing",
             WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $fatal(1, "timeout");
  end

  initial begin : main_sequence
    int n;
    void'($urandom(32'h376c));
    rst_n      = 1'b0;
    wr_en      = 1'b0;
    wr_idx     = '0;
    wr_data    = '0;
    mem_enable = 1'b0;
    n          = 0;
    for (int i = 0; i < NUM_VEC * FIELDS; i++) vec_mem[i] = '1;
    $readmemh("bench/rv_front_vectors.txt", vec_mem);
    if (vec_mem[NUM_VEC*FIELDS-1] === '1) begin
      $display("vector file is missing or holds fewer than %0d vectors", NUM_VEC);
      $display("ERRORS FOUND");
      $fatal(1, "bad vector file");
    end
    reg_copy[0] = '0;

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      compare_value("reset cyc", 64'd0, 64'(wb.cyc));
      compare_value("reset stb", 64'd0, 64'(wb.stb));
      compare_value("reset issue_valid", 64'd0, 64'(issue_valid));
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_value("release cyc", 64'd0, 64'(wb.cyc));
    compare_value("release stb", 64'd0, 64'(wb.stb));
    compare_value("release issue_valid", 64'd0, 64'(issue_valid));

    load_registers();

    // one bundle per handshake, in vector order
    while (n < NUM_VEC) begin
      @(posedge clk);
      if (issue_valid && issue_ready) begin
        verify_bundle(n);
        n++;
      end
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/rv_front_vectors.txt */
// inst rs1 rs2 rd imm need_rs1 need_rs2 need_rd need_imm alu_op mem_op exc_op pc_op
// all hex, one vector per line, op codes in rv_front_pkg enum order
80000337 00 00 06 ffffffff80000000 0 0 1 1 0 0 2 0
00001397 00 00 07 0000000000001000 0 0 1 1 0 0 1 0
ffdff0ef 00 00 01 fffffffffffffffc 0 0 1 1 0 0 3 2
008100e7 02 00 01 0000000000000008 1 0 1 1 0 0 4 3
00418463 03 04 00 0000000000000008 1 1 0 1 0 0 7 1
fe629ce3 05 06 00 fffffffffffffff8 1 1 0 1 0 0 7 1
0083c0e3 07 08 00 0000000000000800 1 1 0 1 0 0 7 1
02a4d063 09 0a 00 0000000000000020 1 1 0 1 0 0 7 1
00c5e263 0b 0c 00 0000000000000004 1 1 0 1 0 0 7 1
fee6ffe3 0d 0e 00 fffffffffffffffe 1 1 0 1 0 0 7 1
00080783 10 00 0f 0000000000000000 1 0 1 1 0 1 5 0
fff91883 12 00 11 ffffffffffffffff 1 0 1 1 0 2 5 0
7ffa2983 14 00 13 00000000000007ff 1 0 1 1 0 3 5 0
010b3a83 16 00 15 0000000000000010 1 0 1 1 0 4 5 0
ff0c4b83 18 00 17 fffffffffffffff0 1 0 1 1 0 5 5 0
002d5c83 1a 00 19 0000000000000002 1 0 1 1 0 6 5 0
004e6d83 1c 00 1b 0000000000000004 1 0 1 1 0 7 5 0
01df00a3 1e 1d 00 0000000000000001 1 1 0 1 0 8 6 0
fff09f23 01 1f 00 fffffffffffffffe 1 1 0 1 0 9 6 0
0421a023 03 02 00 0000000000000040 1 1 0 1 0 a 6 0
00023423 04 00 00 0000000000000008 1 1 0 1 0 b 6 0
fff34293 06 00 05 ffffffffffffffff 1 0 1 1 2 0 8 0
42345393 08 00 07 0000000000000423 1 0 1 1 7 0 8 0
40b504b3 0a 0b 09 0000000000000000 1 1 1 0 1 0 a 0
40e6d63b 0d 0e 0c 0000000000000000 1 1 1 0 7 0 b 0
0038179b 10 00 0f 0000000000000003 1 0 1 1 5 0 9 0
033908b3 12 13 11 0000000000000000 1 1 1 0 0 0 a 0
00000073 00 00 00 0000000000000000 0 0 0 0 0 0 0 0
0ff0000f 00 00 00 0000000000000000 0 0 0 0 0 0 0 0

/* list.f */
design/rv_front_pkg.sv
design/inst_fetch.sv
design/inst_decode.sv
design/reg_file.sv
design/decode_stage.sv
design/rv_front_top.sv
bench/tb_rv_front.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_front
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
